/* command_frontend.f */
+incdir+common
common/raster_cmd_pkg.sv
src/serial_to_parallel.sv
src/command_input.sv
model_buffer/model_buffer.sv
scene_buffer/scene_buffer.sv
src/command_frontend.sv
verification/clock_gen.sv
verification/command_frontend_tb.sv

/* common/raster_cmd_params.svh */
`ifndef RASTER_CMD_PARAMS_SVH
`define RASTER_CMD_PARAMS_SVH

// Number of model slots in the model buffer
`define MODEL_COUNT 4

// Triangle capacity of each model slot
`define TRIS_PER_MODEL 4

// Instance capacity of the scene buffer
`define SCENE_DEPTH 4

// Index widths address a slot, count widths must also hold the full value
`define MODEL_IDX_W ($clog2(`MODEL_COUNT))
`define TRI_IDX_W ($clog2(`TRIS_PER_MODEL))
`define TRI_CNT_W ($clog2(`TRIS_PER_MODEL + 1))
`define SCENE_IDX_W ($clog2(`SCENE_DEPTH))
`define SCENE_CNT_W ($clog2(`SCENE_DEPTH + 1))

`endif

/* common/raster_cmd_pkg.sv */
`default_nettype none

package raster_cmd_pkg;

    // Command opcodes as they appear on the host byte stream
    typedef enum logic [7:0] {
        OP_RESET           = 8'h55,
        OP_BEGIN_MODEL     = 8'hA0,
        OP_UPLOAD_TRIANGLE = 8'hA1,
        OP_ADD_INSTANCE    = 8'hB0
    } cmd_opcode_t;

    // Decoder states, one per command that carries payload
    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_RESET       = 3'd1,
        ST_BEGIN_MODEL = 3'd2,
        ST_TRIANGLE    = 3'd3,
        ST_INSTANCE    = 3'd4
    } cmd_state_t;

    // First field sits in the most significant bits, so the first
    // received byte of a payload lands in x of the first vertex
    typedef struct packed {
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [15:0] z;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        logic [7:0] model_id;
        vertex_t    position;
    } model_instance_t;

    // Only bit 0 of last is meaningful
    typedef struct packed {
        model_instance_t inst;
        logic [7:0]      last;
    } cmd_instance_t;

    typedef struct packed {
        logic [7:0] model_id;
        triangle_t  triangle;
    } model_write_t;

endpackage

`default_nettype wire

/* model_buffer/model_buffer.sv */
`default_nettype none

`include "raster_cmd_params.svh"

module model_buffer (
    input  wire logic                         clk,
    input  wire logic                         rstn,
    input  wire logic                         clear,
    input  wire logic                         wr_valid,
    output logic                              wr_ready,
    input  wire raster_cmd_pkg::model_write_t wr_data,
    input  wire logic [`MODEL_IDX_W-1:0]      rd_model,
    input  wire logic [`TRI_IDX_W-1:0]        rd_index,
    output raster_cmd_pkg::triangle_t         rd_data,
    output logic [`TRI_CNT_W-1:0]             rd_count
);
    import raster_cmd_pkg::*;

    localparam int IDX_W = `MODEL_IDX_W;
    localparam int CNT_W = `TRI_CNT_W;

    triangle_t              mem    [`MODEL_COUNT][`TRIS_PER_MODEL];
    logic [CNT_W-1:0]       counts [`MODEL_COUNT];
    logic                   clearing;
    logic [IDX_W-1:0]       clear_idx;
    logic [IDX_W-1:0]       wr_model;
    logic                   wr_fire;
    logic                   wr_store;

    assign wr_ready = !clearing;
    assign wr_fire  = wr_valid && wr_ready;
    assign wr_model = wr_data.model_id[IDX_W-1:0];

    // A full model still consumes the write, the triangle is just lost
    assign wr_store = wr_fire && (counts[wr_model] != CNT_W'(`TRIS_PER_MODEL));

    always_ff @(posedge clk) begin
        if (wr_store) begin
            mem[wr_model][counts[wr_model][`TRI_IDX_W-1:0]] <= wr_data.triangle;
        end
    end

    // Sweep zeroes one model count per cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            clearing  <= 1'b0;
            clear_idx <= '0;
            for (int m = 0; m < `MODEL_COUNT; m++) begin
                counts[m] <= '0;
            end
        end else if (clear) begin
            clearing  <= 1'b1;
            clear_idx <= '0;
        end else if (clearing) begin
            counts[clear_idx] <= '0;
            clear_idx         <= clear_idx + 1'b1;
            if (clear_idx == IDX_W'(`MODEL_COUNT - 1)) begin
                clearing <= 1'b0;
            end
        end else if (wr_store) begin
            counts[wr_model] <= counts[wr_model] + 1'b1;
        end
    end

    assign rd_data  = mem[rd_model][rd_index];
    assign rd_count = counts[rd_model];

    a_model_in_range : assert property (@(posedge clk) disable iff (!rstn)
        wr_fire |-> (wr_data.model_id < `MODEL_COUNT))
        else $error("triangle written to model %0d", wr_data.model_id);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f command_frontend.f \
    --top-module command_frontend_tb -o command_frontend_sim \
    && ./obj_dir/command_frontend_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"

/* scene_buffer/scene_buffer.sv */
`default_nettype none

`include "raster_cmd_params.svh"

module scene_buffer (
    input  wire logic                          clk,
    input  wire logic                          rstn,
    input  wire logic                          clear,
    input  wire logic                          wr_valid,
    output logic                               wr_ready,
    input  wire raster_cmd_pkg::cmd_instance_t wr_data,
    input  wire logic [`SCENE_IDX_W-1:0]       rd_index,
    output raster_cmd_pkg::model_instance_t    rd_data,
    output logic [`SCENE_CNT_W-1:0]            count,
    output logic                               frame_done
);
    import raster_cmd_pkg::*;

    localparam int CNT_W = `SCENE_CNT_W;

    model_instance_t mem [`SCENE_DEPTH];
    logic            full;
    logic            wr_store;

    assign full = (count == CNT_W'(`SCENE_DEPTH));

    // On a clear the buffer also swallows an instance stuck at its input
    assign wr_ready = !full || clear;
    assign wr_store = wr_valid && wr_ready && !clear;

    always_ff @(posedge clk) begin
        if (wr_store) begin
            mem[count[`SCENE_IDX_W-1:0]] <= wr_data.inst;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count      <= '0;
            frame_done <= 1'b0;
        end else if (clear) begin
            count      <= '0;
            frame_done <= 1'b0;
        end else if (wr_store) begin
            count <= count + 1'b1;
            if (wr_data.last[0]) begin
                frame_done <= 1'b1;
            end
        end
    end

    assign rd_data = mem[rd_index];

    // Once full, only a clear brings the count down
    a_full_holds : assert property (@(posedge clk) disable iff (!rstn)
        full && !clear |=> count == CNT_W'(`SCENE_DEPTH))
        else $error("scene count moved while full");

endmodule

`default_nettype wire

/* src/command_frontend.sv */
`default_nettype none

`include "raster_cmd_params.svh"

module command_frontend (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic                       cmd_in_valid,
    output logic                            cmd_in_ready,
    input  wire logic [7:0]                 cmd_in_data,
    input  wire logic [`MODEL_IDX_W-1:0]    tri_rd_model,
    input  wire logic [`TRI_IDX_W-1:0]      tri_rd_index,
    output raster_cmd_pkg::triangle_t       tri_rd_data,
    output logic [`TRI_CNT_W-1:0]           tri_count,
    input  wire logic [`SCENE_IDX_W-1:0]    inst_rd_index,
    output raster_cmd_pkg::model_instance_t inst_rd_data,
    output logic [`SCENE_CNT_W-1:0]         inst_count,
    output logic                            frame_done
);
    import raster_cmd_pkg::*;

    logic          model_valid;
    logic          model_ready;
    model_write_t  model_data;
    logic          scene_valid;
    logic          scene_ready;
    cmd_instance_t scene_data;
    logic          cmd_reset;

    command_input u_command_input (
        .clk          (clk),
        .rstn         (rstn),
        .cmd_in_valid (cmd_in_valid),
        .cmd_in_ready (cmd_in_ready),
        .cmd_in_data  (cmd_in_data),
        .model_valid  (model_valid),
        .model_ready  (model_ready),
        .model_data   (model_data),
        .scene_valid  (scene_valid),
        .scene_ready  (scene_ready),
        .scene_data   (scene_data),
        .cmd_reset    (cmd_reset)
    );

    // Triangle storage, indexed by model and slot
    model_buffer u_model_buffer (
        .clk      (clk),
        .rstn     (rstn),
        .clear    (cmd_reset),
        .wr_valid (model_valid),
        .wr_ready (model_ready),
        .wr_data  (model_data),
        .rd_model (tri_rd_model),
        .rd_index (tri_rd_index),
        .rd_data  (tri_rd_data),
        .rd_count (tri_count)
    );

    // Instance list for the current frame
    scene_buffer u_scene_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .clear      (cmd_reset),
        .wr_valid   (scene_valid),
        .wr_ready   (scene_ready),
        .wr_data    (scene_data),
        .rd_index   (inst_rd_index),
        .rd_data    (inst_rd_data),
        .count      (inst_count),
        .frame_done (frame_done)
    );

endmodule

`default_nettype wire

/* src/command_input.sv */
`default_nettype none

module command_input (
    input  wire logic                         clk,
    input  wire logic                         rstn,
    input  wire logic                         cmd_in_valid,
    output logic                              cmd_in_ready,
    input  wire logic [7:0]                   cmd_in_data,
    output logic                              model_valid,
    input  wire logic                         model_ready,
    output raster_cmd_pkg::model_write_t      model_data,
    output logic                              scene_valid,
    input  wire logic                         scene_ready,
    output raster_cmd_pkg::cmd_instance_t     scene_data,
    output logic                              cmd_reset
);
    import raster_cmd_pkg::*;

    localparam int TRI_BYTES  = $bits(triangle_t) / 8;
    localparam int INST_BYTES = $bits(cmd_instance_t) / 8;
    localparam int LEFT_W     = $clog2(TRI_BYTES + 1);

    // Payload bytes that follow each opcode
    function automatic logic [LEFT_W-1:0] payload_len(cmd_opcode_t op);
        case (op)
            OP_RESET:           return LEFT_W'(1);
            OP_BEGIN_MODEL:     return LEFT_W'(1);
            OP_UPLOAD_TRIANGLE: return LEFT_W'(TRI_BYTES);
            OP_ADD_INSTANCE:    return LEFT_W'(INST_BYTES);
            default:            return '0;
        endcase
    endfunction

    // Unknown opcodes keep the decoder in idle
    function automatic cmd_state_t op_state(cmd_opcode_t op);
        case (op)
            OP_RESET:           return ST_RESET;
            OP_BEGIN_MODEL:     return ST_BEGIN_MODEL;
            OP_UPLOAD_TRIANGLE: return ST_TRIANGLE;
            OP_ADD_INSTANCE:    return ST_INSTANCE;
            default:            return ST_IDLE;
        endcase
    endfunction

    cmd_state_t        state;
    cmd_state_t        state_d;
    logic [LEFT_W-1:0] bytes_left;
    logic [LEFT_W-1:0] bytes_left_d;
    logic              reset_d;
    logic [7:0]        model_idx;
    cmd_opcode_t       opcode;
    logic              in_fire;

    logic              tri_in_valid;
    logic              tri_in_ready;
    triangle_t         tri_word;
    logic              inst_in_valid;
    logic              inst_in_ready;
    logic              sync;

    assign opcode  = cmd_opcode_t'(cmd_in_data);
    assign in_fire = cmd_in_valid && cmd_in_ready;

    // Both deserializers start from an empty word for every command
    assign sync = (state == ST_IDLE);

    assign tri_in_valid  = in_fire && (state == ST_TRIANGLE);
    assign inst_in_valid = in_fire && (state == ST_INSTANCE);

    always_comb begin
        case (state)
            ST_TRIANGLE: cmd_in_ready = tri_in_ready;
            ST_INSTANCE: cmd_in_ready = inst_in_ready;
            default:     cmd_in_ready = 1'b1;
        endcase
    end

    always_comb begin
        state_d      = state;
        bytes_left_d = bytes_left;
        reset_d      = 1'b0;
        if (in_fire) begin
            case (state)
                ST_IDLE: begin
                    state_d      = op_state(opcode);
                    bytes_left_d = payload_len(opcode);
                end
                ST_RESET: begin
                    if (opcode == OP_RESET) begin
                        reset_d      = 1'b1;
                        state_d      = ST_IDLE;
                        bytes_left_d = '0;
                    end else begin
                        // Not a reset after all, this byte opens the next command
                        state_d      = op_state(opcode);
                        bytes_left_d = payload_len(opcode);
                    end
                end
                default: begin
                    bytes_left_d = bytes_left - 1'b1;
                    if (bytes_left == LEFT_W'(1)) begin
                        state_d = ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= ST_IDLE;
            bytes_left <= '0;
            cmd_reset  <= 1'b0;
            model_idx  <= '0;
        end else begin
            state      <= state_d;
            bytes_left <= bytes_left_d;
            cmd_reset  <= reset_d;
            if (in_fire && state == ST_BEGIN_MODEL) begin
                model_idx <= cmd_in_data;
            end
        end
    end

    assign model_data = '{model_id: model_idx, triangle: tri_word};

    serial_to_parallel #(
        .IN_WIDTH  (8),
        .OUT_WIDTH ($bits(triangle_t))
    ) u_tri_deser (
        .clk                (clk),
        .rstn               (rstn),
        .sync               (sync),
        .serial_in_valid    (tri_in_valid),
        .serial_in_ready    (tri_in_ready),
        .serial_in_data     (cmd_in_data),
        .parallel_out_valid (model_valid),
        .parallel_out_ready (model_ready),
        .parallel_out_data  (tri_word)
    );

    serial_to_parallel #(
        .IN_WIDTH  (8),
        .OUT_WIDTH ($bits(cmd_instance_t))
    ) u_inst_deser (
        .clk                (clk),
        .rstn               (rstn),
        .sync               (sync),
        .serial_in_valid    (inst_in_valid),
        .serial_in_ready    (inst_in_ready),
        .serial_in_data     (cmd_in_data),
        .parallel_out_valid (scene_valid),
        .parallel_out_ready (scene_ready),
        .parallel_out_data  (scene_data)
    );

    a_reset_pulse : assert property (@(posedge clk) disable iff (!rstn)
        cmd_reset |=> !cmd_reset)
        else $error("cmd_reset held for more than one cycle");

    a_state_legal : assert property (@(posedge clk) disable iff (!rstn)
        state inside {ST_IDLE, ST_RESET, ST_BEGIN_MODEL, ST_TRIANGLE, ST_INSTANCE})
        else $error("decoder state %0d out of range", state);

endmodule

`default_nettype wire

/* src/serial_to_parallel.sv */
`default_nettype none

module serial_to_parallel #(
    parameter int IN_WIDTH  = 8,
    parameter int OUT_WIDTH = 32
) (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 sync,
    input  wire logic                 serial_in_valid,
    output logic                      serial_in_ready,
    input  wire logic [IN_WIDTH-1:0]  serial_in_data,
    output logic                      parallel_out_valid,
    input  wire logic                 parallel_out_ready,
    output logic [OUT_WIDTH-1:0]      parallel_out_data
);
    localparam int WORDS = OUT_WIDTH / IN_WIDTH;
    localparam int CNT_W = $clog2(WORDS + 1);

    logic [OUT_WIDTH-1:0] shift_reg;
    logic [CNT_W-1:0]     fill;
    logic                 full;
    logic                 in_fire;
    logic                 out_fire;

    assign full     = (fill == CNT_W'(WORDS));
    assign out_fire = full && parallel_out_ready;
    assign in_fire  = serial_in_valid && serial_in_ready;

    // A held word blocks input unless it leaves on this same edge
    assign serial_in_ready    = !full || parallel_out_ready;
    assign parallel_out_valid = full;
    assign parallel_out_data  = shift_reg;

    // New data enters at the bottom, so the oldest input ends up on top
    always_ff @(posedge clk) begin
        if (in_fire) begin
            shift_reg <= (shift_reg << IN_WIDTH) | OUT_WIDTH'(serial_in_data);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fill <= '0;
        end else if (out_fire && in_fire) begin
            fill <= CNT_W'(1);
        end else if (out_fire) begin
            fill <= '0;
        end else if (in_fire) begin
            fill <= fill + 1'b1;
        end else if (sync && !full) begin
            // Drop a partial word, a complete one still waits for its consumer
            fill <= '0;
        end
    end

    a_whole_words : assert property (@(posedge clk) disable iff (!rstn)
        (OUT_WIDTH % IN_WIDTH) == 0)
        else $error("OUT_WIDTH %0d is not a multiple of IN_WIDTH %0d", OUT_WIDTH, IN_WIDTH);

endmodule

`default_nettype wire

/* verification/clock_gen.sv */
`default_nettype none

module clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstn
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released on a rising edge after the hold time
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

`default_nettype wire

/* verification/command_frontend_tb.sv */
`default_nettype none

`include "raster_cmd_params.svh"

module command_frontend_tb;
    import raster_cmd_pkg::*;

    localparam int NUM_ROWS    = 11;
    localparam int MAX_GAP     = 3;
    localparam int IDLE_CYCLES = 8;

    // Slot data is compared only where the expected count is nonzero
    typedef struct packed {
        int                      stop;
        logic [`MODEL_IDX_W-1:0] rd_model;
        logic [`TRI_IDX_W-1:0]   rd_index;
        logic [`TRI_CNT_W-1:0]   tri_count;
        triangle_t               tri_data;
        logic [`SCENE_IDX_W-1:0] inst_index;
        logic [`SCENE_CNT_W-1:0] inst_count;
        model_instance_t         inst_data;
        logic                    frame_done;
    } test_row_t;

    logic                    clk;
    logic                    rstn;
    logic                    cmd_in_valid;
    logic                    cmd_in_ready;
    logic [7:0]              cmd_in_data;
    logic [`MODEL_IDX_W-1:0] tri_rd_model;
    logic [`TRI_IDX_W-1:0]   tri_rd_index;
    triangle_t               tri_rd_data;
    logic [`TRI_CNT_W-1:0]   tri_count;
    logic [`SCENE_IDX_W-1:0] inst_rd_index;
    model_instance_t         inst_rd_data;
    logic [`SCENE_CNT_W-1:0] inst_count;
    logic                    frame_done;

    logic [7:0]      stim_q [$];
    test_row_t       rows [NUM_ROWS];
    string           names [NUM_ROWS];
    int              row_count = 0;
    logic [31:0]     lfsr = 32'h6c00_5b3f;
    int              error_count = 0;
    int              failed_tests = 0;
    int              cycle_count = 0;
    int              cycle_limit = 1000000;
    triangle_t       tri_exp [8];
    model_instance_t inst_exp [9];

    clock_gen #(.PERIOD(100), .RESET_CYCLES(2)) u_clock_gen (.clk(clk), .rstn(rstn));

    command_frontend DUT (.*);

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic int random_bits(input int n);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic check_value(input string what, input logic [143:0] got,
                               input logic [143:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            error_count++;
        end
    endtask

    // Opcode and 18 payload bytes, first byte in the top byte of the triangle
    task automatic put_tri(input logic [7:0] tag, output triangle_t t);
        logic [7:0] b;
        stim_q.push_back(OP_UPLOAD_TRIANGLE);
        for (int i = 0; i < 18; i++) begin
            b = tag + 8'(i * 7);
            t[143 - 8 * i -: 8] = b;
            stim_q.push_back(b);
        end
    endtask

    // Model id, six position bytes, then the last flag byte
    task automatic put_inst(input logic [7:0] id, input logic [7:0] tag, input logic last,
                            output model_instance_t inst);
        logic [63:0] w;
        w = {id, tag, tag ^ 8'h3c, tag + 8'd9, 8'h80 | tag, tag - 8'd5, ~tag, 7'd0, last};
        stim_q.push_back(OP_ADD_INSTANCE);
        for (int i = 7; i >= 0; i--) begin
            stim_q.push_back(w[8 * i +: 8]);
        end
        inst = w[63:8];
    endtask

    task automatic end_row(input string name, input logic [`MODEL_IDX_W-1:0] rm,
                           input logic [`TRI_IDX_W-1:0] ri, input logic [`TRI_CNT_W-1:0] tc,
                           input triangle_t t, input logic [`SCENE_IDX_W-1:0] ii,
                           input logic [`SCENE_CNT_W-1:0] ic, input model_instance_t inst,
                           input logic done);
        rows[row_count]  = '{stim_q.size(), rm, ri, tc, t, ii, ic, inst, done};
        names[row_count] = name;
        row_count++;
    endtask

    task automatic build_table();
        end_row("state after reset", 0, 0, 0, '0, 0, 0, '0, 0);
        stim_q.push_back(OP_BEGIN_MODEL);
        stim_q.push_back(8'd2);
        put_tri(8'h10, tri_exp[0]);
        put_tri(8'h20, tri_exp[1]);
        end_row("two triangles to model 2", 2, 1, 2, tri_exp[1], 0, 0, '0, 0);
        stim_q.push_back(OP_BEGIN_MODEL);
        stim_q.push_back(8'd1);
        put_tri(8'h30, tri_exp[2]);
        end_row("one triangle to model 1", 1, 0, 1, tri_exp[2], 0, 0, '0, 0);
        stim_q.push_back(OP_BEGIN_MODEL);
        stim_q.push_back(8'd2);
        put_tri(8'h40, tri_exp[3]);
        put_tri(8'h50, tri_exp[4]);
        put_tri(8'h60, tri_exp[5]);
        end_row("fifth triangle dropped", 2, 3, 4, tri_exp[4], 0, 0, '0, 0);
        put_inst(8'd1, 8'h71, 1'b0, inst_exp[0]);
        put_inst(8'd2, 8'h82, 1'b0, inst_exp[1]);
        end_row("two instances", 2, 0, 4, tri_exp[0], 1, 2, inst_exp[1], 0);
        put_inst(8'd3, 8'h93, 1'b1, inst_exp[2]);
        end_row("flagged instance", 1, 0, 1, tri_exp[2], 2, 3, inst_exp[2], 1);
        // Unknown byte, then a lone reset byte followed by a real command
        stim_q.push_back(8'h3c);
        stim_q.push_back(OP_RESET);
        stim_q.push_back(OP_BEGIN_MODEL);
        stim_q.push_back(8'd3);
        put_tri(8'h70, tri_exp[6]);
        end_row("ignored opcodes", 3, 0, 1, tri_exp[6], 0, 3, inst_exp[0], 1);
        stim_q.push_back(OP_RESET);
        stim_q.push_back(OP_RESET);
        put_tri(8'h80, tri_exp[7]);
        end_row("upload after reset", 3, 0, 1, tri_exp[7], 0, 0, '0, 0);
        end_row("model 2 cleared", 2, 0, 0, '0, 0, 0, '0, 0);
        for (int k = 0; k < `SCENE_DEPTH + 1; k++) begin
            put_inst(8'(k % 4), 8'(k * 16 + 5), 1'b0, inst_exp[3 + k]);
        end
        end_row("scene full", 1, 0, 0, '0, 3, 4, inst_exp[6], 0);
        stim_q.push_back(OP_RESET);
        stim_q.push_back(OP_RESET);
        put_inst(8'd2, 8'hc4, 1'b1, inst_exp[8]);
        end_row("reset recovers scene", 3, 0, 0, '0, 0, 1, inst_exp[8], 1);
    endtask

    // Optional idle gap, then hold the byte until the DUT takes it
    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = random_bits(2);
        if (gap > 0) begin
            cmd_in_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        cmd_in_valid <= 1'b1;
        cmd_in_data  <= b;
        @(negedge clk);
        while (!cmd_in_ready) @(negedge clk);
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: no result after %0d cycles", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int next;
        int errors_before;
        cmd_in_valid  = 1'b0;
        cmd_in_data   = '0;
        tri_rd_model  = '0;
        tri_rd_index  = '0;
        inst_rd_index = '0;
        build_table();
        cycle_limit = stim_q.size() * (MAX_GAP + 1) + NUM_ROWS * (IDLE_CYCLES + 2) + 200;
        next = 0;
        wait (rstn);
        @(posedge clk);
        for (int r = 0; r < row_count; r++) begin
            errors_before = error_count;
            while (next < rows[r].stop) begin
                send_byte(stim_q[next]);
                next++;
            end
            cmd_in_valid <= 1'b0;
            repeat (IDLE_CYCLES) @(posedge clk);
            tri_rd_model  <= rows[r].rd_model;
            tri_rd_index  <= rows[r].rd_index;
            inst_rd_index <= rows[r].inst_index;
            @(negedge clk);
            check_value("cmd_in_ready", 144'(cmd_in_ready), 144'(1'b1));
            check_value("tri_count", 144'(tri_count), 144'(rows[r].tri_count));
            if (rows[r].tri_count != 0) begin
                check_value("triangle", tri_rd_data, rows[r].tri_data);
            end
            check_value("inst_count", 144'(inst_count), 144'(rows[r].inst_count));
            if (rows[r].inst_count != 0) begin
                check_value("instance", 144'(inst_rd_data), 144'(rows[r].inst_data));
            end
            check_value("frame_done", 144'(frame_done), 144'(rows[r].frame_done));
            if (error_count != errors_before) begin
                failed_tests++;
            end
            $display("Test %0d (%s): %s", r, names[r],
                     (error_count == errors_before) ? "pass" : "fail");
            @(posedge clk);
        end
        $display("Tests %0d, failed %0d, mismatches %0d", row_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
